//--- rtl/rgmii_pkg.sv
package rgmii_pkg;

    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int AXIL_DATA_WIDTH = 32;
    localparam int RGMII_WIDTH     = 4;
    localparam int PAYLOAD_WIDTH   = 11;
    localparam int RGMII_REG_NUM   = 7;
    localparam int REG_IDX_WIDTH   = $clog2(RGMII_REG_NUM);
    localparam int REG_STATUS      = 5; // first word that is not plain read/write.

    localparam int PREAMBLE_BYTES = 8;  // includes the SFD.
    localparam int MAC_BYTES      = 6;
    localparam int HDR_BYTES      = 14;
    localparam int FCS_BYTES      = 4;
    localparam int GAP_BYTES      = 12;
    localparam int RX_LINE_BYTES  = FCS_BYTES + 1;

    localparam logic [15:0] ETH_TYPE      = 16'h88B5;
    localparam logic [31:0] CRC_POLY      = 32'hEDB88320; // reflected 802.3 polynomial.
    localparam logic [31:0] CRC_RESIDUE   = 32'hDEBB20E3;
    localparam logic [1:0]  AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [4:0]               rsvd_hi;
        logic [PAYLOAD_WIDTH-1:0] payload_bytes;
        logic [14:0]              rsvd_lo;
        logic                     check_destination;
    } control_t;

    typedef struct packed {
        logic [15:0] rsvd;
        logic [15:0] mac;
    } mac_hi_t;

    typedef struct packed {
        logic [30:0] rsvd;
        logic        crc_err;
    } status_t;

    typedef struct packed {
        logic [15:0] rsvd;
        logic [7:0]  payload_width;
        logic [7:0]  reg_num;
    } param_t;

    // highest word first, so word 0 is control.
    typedef struct packed {
        param_t      param;
        status_t     status;
        mac_hi_t     mac_host_hi;
        logic [31:0] mac_host_lo;
        mac_hi_t     mac_fpga_hi;
        logic [31:0] mac_fpga_lo;
        control_t    control;
    } rgmii_fields_t;

    typedef union packed {
        logic [RGMII_REG_NUM-1:0][AXIL_DATA_WIDTH-1:0] words;
        rgmii_fields_t                                 fields;
    } rgmii_regs_u;

    typedef struct packed {
        logic                       awvalid;
        logic [AXIL_ADDR_WIDTH-1:0] awaddr;
        logic                       wvalid;
        logic [AXIL_DATA_WIDTH-1:0] wdata;
        logic                       bready;
        logic                       arvalid;
        logic [AXIL_ADDR_WIDTH-1:0] araddr;
        logic                       rready;
    } axil_req_t;

    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic                       bvalid;
        logic [1:0]                 bresp;
        logic                       arready;
        logic                       rvalid;
        logic [AXIL_DATA_WIDTH-1:0] rdata;
        logic [1:0]                 rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic       tvalid;
        logic [7:0] tdata;
        logic       tlast;
    } axis_t;

    localparam rgmii_regs_u RGMII_REG_INIT = {
        32'h0000_0B07, // param.
        32'h0000_0000, // status.
        32'h0000_0200, // host mac 02:00:..
        32'h0000_0001, // ..00:00:00:01.
        32'h0000_0200,
        32'h0000_0001,
        32'h0040_0000  // 64 payload bytes, no destination check.
    };

endpackage

//--- rtl/eth_crc32.sv
`timescale 1ns/100ps

module eth_crc32
    import rgmii_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        init_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o,
    output logic        residue_ok_o
);

    logic [31:0] crc_q;

    // lsb first, one bit per step.
    function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (c[0] ^ data[i]) ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crc_q <= '1;
        end else if (init_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next(crc_q, data_i);
        end
    end

    assign crc_o        = ~crc_q; // fcs, sent low byte first.
    assign residue_ok_o = (crc_q == CRC_RESIDUE);

endmodule

//--- rtl/axil_reg_file.sv
`timescale 1ns/100ps

module axil_reg_file
    import rgmii_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  axil_req_t   axil_req_i,
    output axil_rsp_t   axil_rsp_o,
    input  logic        crc_err_i,
    output rgmii_regs_u regs_o
);

    rgmii_regs_u                regs_q;
    logic                       crc_err_q;
    logic                       bvalid_q;
    logic                       rvalid_q;
    logic [AXIL_DATA_WIDTH-1:0] rdata_q;
    logic [AXIL_ADDR_WIDTH-3:0] wr_word;
    logic [AXIL_ADDR_WIDTH-3:0] rd_word;
    logic                       wr_en;
    logic                       rd_en;

    assign wr_word = axil_req_i.awaddr[AXIL_ADDR_WIDTH-1:2];
    assign rd_word = axil_req_i.araddr[AXIL_ADDR_WIDTH-1:2];
    assign wr_en   = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
    assign rd_en   = axil_req_i.arvalid && !rvalid_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q    <= RGMII_REG_INIT;
            crc_err_q <= 1'b0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            if (wr_en && wr_word < REG_STATUS) begin
                regs_q.words[wr_word[REG_IDX_WIDTH-1:0]] <= axil_req_i.wdata;
            end
            if (crc_err_i) begin
                crc_err_q <= 1'b1; // a new error wins over a clear.
            end else if (wr_en && wr_word == REG_STATUS && axil_req_i.wdata[0]) begin
                crc_err_q <= 1'b0;
            end
            if (wr_en) begin
                bvalid_q <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= (rd_word < RGMII_REG_NUM) ? regs_o.words[rd_word[REG_IDX_WIDTH-1:0]] : '0;
        end
    end

    always_comb begin
        regs_o                            = regs_q;
        regs_o.fields.status.crc_err      = crc_err_q;
        regs_o.fields.param.reg_num       = 8'(RGMII_REG_NUM);
        regs_o.fields.param.payload_width = 8'(PAYLOAD_WIDTH);
    end

    assign axil_rsp_o.awready = wr_en;
    assign axil_rsp_o.wready  = wr_en;
    assign axil_rsp_o.bvalid  = bvalid_q;
    assign axil_rsp_o.bresp   = AXI_RESP_OKAY;
    assign axil_rsp_o.arready = rd_en;
    assign axil_rsp_o.rvalid  = rvalid_q;
    assign axil_rsp_o.rdata   = rdata_q;
    assign axil_rsp_o.rresp   = AXI_RESP_OKAY;

    a_bvalid_held : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

endmodule

//--- rtl/rgmii_tx.sv
`timescale 1ns/100ps

module rgmii_tx
    import rgmii_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  rgmii_fields_t          cfg_i,
    input  axis_t                  s_axis_i,
    output logic                   s_axis_tready_o,
    output logic [RGMII_WIDTH-1:0] eth_txd_o,
    output logic                   eth_tx_ctl_o
);

    // listed in frame order.
    typedef enum logic [2:0] {
        ST_IDLE, ST_PRE, ST_HDR, ST_PAY, ST_FCS, ST_GAP
    } state_t;

    state_t                   state_q;
    logic                     ph_q;
    logic [PAYLOAD_WIDTH-1:0] cnt_q;
    logic [PAYLOAD_WIDTH-1:0] len_q;
    logic [8*HDR_BYTES-1:0]   hdr_q;
    logic [7:0]               cur_q;
    logic [7:0]               tx_byte;
    logic [31:0]              fcs;
    logic                     crc_en;
    logic                     last_byte;

    assign s_axis_tready_o = (state_q == ST_PAY) && !ph_q;
    assign tx_byte = !s_axis_tready_o ? cur_q : (s_axis_i.tvalid ? s_axis_i.tdata : 8'h00);
    assign eth_txd_o = ph_q ? cur_q[7:4] : tx_byte[3:0];
    assign eth_tx_ctl_o = state_q inside {ST_PRE, ST_HDR, ST_PAY, ST_FCS};
    assign crc_en = !ph_q && (state_q inside {ST_HDR, ST_PAY});

    always_comb begin
        case (state_q)
            ST_PRE:  last_byte = (cnt_q == PREAMBLE_BYTES - 1);
            ST_HDR:  last_byte = (cnt_q == HDR_BYTES - 1);
            ST_PAY:  last_byte = (cnt_q == len_q - 1'b1);
            ST_FCS:  last_byte = (cnt_q == FCS_BYTES - 1);
            ST_GAP:  last_byte = (cnt_q == GAP_BYTES - 1);
            default: last_byte = 1'b0;
        endcase
    end

    eth_crc32 i_eth_crc32 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .init_i      (state_q == ST_PRE),
        .en_i        (crc_en),
        .data_i      (tx_byte),
        .crc_o       (fcs),
        .residue_ok_o()
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            ph_q    <= 1'b0;
            cnt_q   <= '0;
        end else if (state_q == ST_IDLE) begin
            ph_q  <= 1'b0;
            cnt_q <= '0;
            if (s_axis_i.tvalid && cfg_i.control.payload_bytes != '0) begin
                state_q <= ST_PRE;
            end
        end else begin
            ph_q <= !ph_q;
            if (ph_q) begin
                cnt_q <= last_byte ? '0 : cnt_q + 1'b1;
                if (last_byte) begin
                    state_q <= state_q.next(); // gap wraps back to idle.
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE) begin
            len_q <= cfg_i.control.payload_bytes;
            hdr_q <= {cfg_i.mac_host_hi.mac, cfg_i.mac_host_lo,
                      cfg_i.mac_fpga_hi.mac, cfg_i.mac_fpga_lo, ETH_TYPE};
            cur_q <= 8'h55;
        end else if (!ph_q) begin
            cur_q <= tx_byte; // holds the payload byte for its high nibble.
        end else begin
            case (state_q)
                ST_PRE: begin
                    if (last_byte) begin
                        cur_q <= hdr_q[8*HDR_BYTES-1 -: 8];
                        hdr_q <= hdr_q << 8;
                    end else begin
                        cur_q <= (cnt_q == PREAMBLE_BYTES - 2) ? 8'hD5 : 8'h55;
                    end
                end
                ST_HDR: begin
                    cur_q <= hdr_q[8*HDR_BYTES-1 -: 8];
                    hdr_q <= hdr_q << 8;
                end
                ST_PAY:  cur_q <= fcs[7:0];
                ST_FCS:  cur_q <= 8'(fcs >> (8 * (cnt_q[1:0] + 2'd1)));
                default: cur_q <= cur_q;
            endcase
        end
    end

    a_tlast_at_end : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s_axis_i.tvalid && s_axis_tready_o && s_axis_i.tlast |-> cnt_q == len_q - 1'b1);

endmodule

//--- rtl/rgmii_rx.sv
`timescale 1ns/100ps

module rgmii_rx
    import rgmii_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  rgmii_fields_t          cfg_i,
    input  logic [RGMII_WIDTH-1:0] eth_rxd_i,
    input  logic                   eth_rx_ctl_i,
    output axis_t                  m_axis_o,
    output logic                   crc_err_o
);

    typedef enum logic [1:0] {
        ST_HUNT, ST_DST, ST_SKIP, ST_DATA
    } state_t;

    state_t                        state_q;
    logic                          ph_q;
    logic                          ctl_q;
    logic                          drop_q;
    logic [2:0]                    cnt_q;
    logic [2:0]                    fill_q;
    logic [RGMII_WIDTH-1:0]        lo_q;
    logic [RX_LINE_BYTES-1:0][7:0] line_q;
    logic [7:0]                    rx_byte;
    logic                          byte_v;
    logic                          frame_end;
    logic                          residue_ok;
    logic [8*MAC_BYTES-1:0]        fpga_mac;
    logic                          m_tvalid_q;
    logic                          m_tlast_q;
    logic [7:0]                    m_tdata_q;

    assign rx_byte   = {eth_rxd_i, lo_q};
    assign byte_v    = eth_rx_ctl_i && ph_q;
    assign frame_end = ctl_q && !eth_rx_ctl_i;
    assign fpga_mac  = {cfg_i.mac_fpga_hi.mac, cfg_i.mac_fpga_lo};

    eth_crc32 i_eth_crc32 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .init_i      (state_q == ST_HUNT),
        .en_i        (byte_v && state_q != ST_HUNT),
        .data_i      (rx_byte),
        .crc_o       (),
        .residue_ok_o(residue_ok)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_HUNT;
            ph_q       <= 1'b0;
            ctl_q      <= 1'b0;
            drop_q     <= 1'b0;
            cnt_q      <= '0;
            fill_q     <= '0;
            m_tvalid_q <= 1'b0;
            m_tlast_q  <= 1'b0;
            crc_err_o  <= 1'b0;
        end else begin
            ctl_q      <= eth_rx_ctl_i;
            ph_q       <= eth_rx_ctl_i && !ph_q;
            m_tvalid_q <= 1'b0;
            m_tlast_q  <= 1'b0;
            crc_err_o  <= frame_end && state_q != ST_HUNT && !residue_ok;
            if (!eth_rx_ctl_i) begin
                state_q <= ST_HUNT;
                // flush the byte still held ahead of the fcs.
                if (frame_end && state_q == ST_DATA && fill_q == RX_LINE_BYTES && !drop_q) begin
                    m_tvalid_q <= 1'b1;
                    m_tlast_q  <= 1'b1;
                end
            end else if (byte_v) begin
                cnt_q <= cnt_q + 1'b1;
                case (state_q)
                    ST_HUNT: begin
                        if (rx_byte == 8'hD5) begin
                            state_q <= ST_DST;
                            cnt_q   <= '0;
                            drop_q  <= 1'b0;
                            fill_q  <= '0;
                        end
                    end
                    ST_DST: begin
                        if (cfg_i.control.check_destination &&
                            rx_byte != fpga_mac[8*(MAC_BYTES-1-cnt_q) +: 8]) begin
                            drop_q <= 1'b1;
                        end
                        if (cnt_q == MAC_BYTES - 1) begin
                            state_q <= ST_SKIP;
                            cnt_q   <= '0;
                        end
                    end
                    ST_SKIP: begin
                        if (cnt_q == HDR_BYTES - MAC_BYTES - 1) begin
                            state_q <= ST_DATA;
                        end
                    end
                    default: begin
                        if (fill_q == RX_LINE_BYTES) begin
                            m_tvalid_q <= !drop_q;
                        end else begin
                            fill_q <= fill_q + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!ph_q) begin
            lo_q <= eth_rxd_i; // low nibble comes first.
        end
        if (byte_v && state_q == ST_DATA) begin
            line_q    <= {line_q[RX_LINE_BYTES-2:0], rx_byte};
            m_tdata_q <= line_q[RX_LINE_BYTES-1];
        end else if (frame_end) begin
            m_tdata_q <= line_q[RX_LINE_BYTES-1];
        end
    end

    assign m_axis_o.tvalid = m_tvalid_q;
    assign m_axis_o.tdata  = m_tdata_q;
    assign m_axis_o.tlast  = m_tlast_q;

endmodule

//--- rtl/axil_rgmii.sv
`timescale 1ns/100ps

module axil_rgmii
    import rgmii_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    input  axil_req_t              s_axil_req_i,
    output axil_rsp_t              s_axil_rsp_o,

    input  axis_t                  s_axis_i,
    output logic                   s_axis_tready_o,
    output axis_t                  m_axis_o,

    output logic [RGMII_WIDTH-1:0] eth_txd_o,
    output logic                   eth_tx_ctl_o,

    input  logic [RGMII_WIDTH-1:0] eth_rxd_i,
    input  logic                   eth_rx_ctl_i
);

    rgmii_regs_u regs;
    logic        crc_err;

    axil_reg_file i_axil_reg_file (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .axil_req_i(s_axil_req_i),
        .axil_rsp_o(s_axil_rsp_o),
        .crc_err_i (crc_err),
        .regs_o    (regs)
    );

    rgmii_tx i_rgmii_tx (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .cfg_i          (regs.fields),
        .s_axis_i       (s_axis_i),
        .s_axis_tready_o(s_axis_tready_o),
        .eth_txd_o      (eth_txd_o),
        .eth_tx_ctl_o   (eth_tx_ctl_o)
    );

    rgmii_rx i_rgmii_rx (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg_i       (regs.fields),
        .eth_rxd_i   (eth_rxd_i),
        .eth_rx_ctl_i(eth_rx_ctl_i),
        .m_axis_o    (m_axis_o),
        .crc_err_o   (crc_err)
    );

endmodule

//--- verif/tb_axil_rgmii.sv
`timescale 1ns/100ps

module tb_axil_rgmii
    import rgmii_pkg::*;
();

    localparam int GAP_CYCLES   = 2 * 12 + 2; // gap plus rx flush.
    localparam int FRAME_CYCLES = 2 * (5 * 38 + 96);
    localparam int CYCLE_LIMIT  = 2 * FRAME_CYCLES + 400;

    logic                   clk = 1'b0;
    logic                   arst_n;
    axil_req_t              req;
    axil_rsp_t              rsp;
    axis_t                  s_axis;
    logic                   s_axis_tready;
    axis_t                  m_axis;
    logic [RGMII_WIDTH-1:0] eth_txd;
    logic                   eth_tx_ctl;
    logic [RGMII_WIDTH-1:0] eth_rxd;

    int          cyc = 0;
    int          tx_nib = 0;
    int          corrupt_at = -1;
    int          tx_rise_cyc = 0;
    int          tready_delay = -1;
    logic        tx_ctl_d = 1'b0;
    logic        tx_half = 1'b0;
    logic [3:0]  tx_lo;
    int unsigned rng = 65;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          mark = 0;
    logic [7:0]  sent[$];
    logic [7:0]  tx_bytes[$];
    logic [7:0]  rx_data[$];
    logic        rx_last[$];
    logic [47:0] mac_a = 48'h02_11_22_33_44_55;
    logic [47:0] mac_b = 48'h00_1A_2B_3C_4D_5E;

    assign eth_rxd = eth_txd ^ ((tx_nib == corrupt_at) ? 4'h1 : 4'h0);

    axil_rgmii i_axil_rgmii (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .s_axil_req_i   (req),
        .s_axil_rsp_o   (rsp),
        .s_axis_i       (s_axis),
        .s_axis_tready_o(s_axis_tready),
        .m_axis_o       (m_axis),
        .eth_txd_o      (eth_txd),
        .eth_tx_ctl_o   (eth_tx_ctl),
        .eth_rxd_i      (eth_rxd),
        .eth_rx_ctl_i   (eth_tx_ctl)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        tx_nib <= eth_tx_ctl ? tx_nib + 1 : 0; // nibble index within the frame.
        if (cyc == CYCLE_LIMIT) begin
            $display("timeout: frames did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // rebuild bytes from the tx pins and time the first tready.
    always @(negedge clk) begin
        if (eth_tx_ctl && !tx_ctl_d) begin
            tx_rise_cyc  = cyc;
            tready_delay = -1;
        end
        if (s_axis_tready && tready_delay < 0) begin
            tready_delay = cyc - tx_rise_cyc;
        end
        if (eth_tx_ctl) begin
            if (tx_half) begin
                tx_bytes.push_back({eth_txd, tx_lo});
            end else begin
                tx_lo = eth_txd;
            end
            tx_half = !tx_half;
        end else begin
            tx_half = 1'b0;
        end
        tx_ctl_d = eth_tx_ctl;
        if (m_axis.tvalid) begin
            rx_data.push_back(m_axis.tdata);
            rx_last.push_back(m_axis.tlast);
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - mark);
        end
        mark = error_count;
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        do begin
            @(negedge clk);
        end while (!rsp.awready);
        check("wready", rsp.wready, 1'b1);
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        req.bready  <= 1'b1;
        do begin
            @(negedge clk);
        end while (!rsp.bvalid);
        check("bresp", rsp.bresp, 2'b00);
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        do begin
            @(negedge clk);
        end while (!rsp.arready);
        @(posedge clk);
        req.arvalid <= 1'b0;
        req.rready  <= 1'b1;
        do begin
            @(negedge clk);
        end while (!rsp.rvalid);
        data = rsp.rdata;
        check("rresp", rsp.rresp, 2'b00);
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    task automatic set_macs(input logic [47:0] fpga, input logic [47:0] host);
        axil_write(32'h04, fpga[31:0]);
        axil_write(32'h08, {16'h0, fpga[47:32]});
        axil_write(32'h0C, host[31:0]);
        axil_write(32'h10, {16'h0, host[47:32]});
    endtask

    task automatic set_control(input logic chk, input int n);
        axil_write(32'h00, {5'b0, n[10:0], 15'b0, chk});
    endtask

    task automatic send_frame(input int n);
        logic [31:0] r;
        int          i;
        sent.delete();
        tx_bytes.delete();
        rx_data.delete();
        rx_last.delete();
        for (i = 0; i < n; i++) begin
            r = next_rand();
            sent.push_back(r[23:16]);
        end
        @(posedge clk);
        s_axis.tvalid <= 1'b1;
        s_axis.tdata  <= sent[0];
        s_axis.tlast  <= (n == 1);
        i = 0;
        while (i < n) begin
            @(negedge clk);
            if (s_axis_tready) begin
                @(posedge clk); // beat taken on this edge.
                i++;
                if (i < n) begin
                    s_axis.tdata <= sent[i];
                    s_axis.tlast <= (i == n - 1);
                end else begin
                    s_axis <= '0;
                end
            end
        end
        do begin
            @(negedge clk);
        end while (eth_tx_ctl);
        repeat (GAP_CYCLES) @(negedge clk);
    endtask

    task automatic check_payload(input int n);
        int k;
        check("rx byte count", rx_data.size(), n);
        if (rx_data.size() == n) begin
            for (k = 0; k < n; k++) begin
                check($sformatf("rx byte %0d", k), rx_data[k], sent[k]);
                check($sformatf("rx tlast %0d", k), rx_last[k], k == n - 1);
            end
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] expv[7];
        logic [31:0] d;
        int          k;
        expv = '{32'h0040_0000, 32'h1, 32'h200, 32'h1, 32'h200, 32'h0, 32'h0B07};
        for (k = 0; k < 7; k++) begin
            axil_read(4 * k, d);
            check($sformatf("reset reg %0d", k), d, expv[k]);
        end
    endtask

    task automatic test_reg_access();
        logic [31:0] val;
        logic [31:0] d;
        int          k;
        for (k = 0; k < 5; k++) begin
            val = next_rand();
            axil_write(4 * k, val);
            axil_read(4 * k, d);
            check($sformatf("reg %0d", k), d, val);
        end
        axil_write(32'h18, 32'hFFFF_FFFF);
        axil_read(32'h18, d);
        check("param", d, 32'h0000_0B07);
        axil_write(32'h1C, 32'h1234_5678);
        axil_read(32'h1C, d);
        check("unmapped 0x1c", d, 32'h0);
        axil_read(32'h100, d);
        check("unmapped 0x100", d, 32'h0);
    endtask

    task automatic test_tx_format();
        int k;
        set_macs(mac_a, mac_b);
        set_control(1'b0, 16);
        send_frame(16);
        check("tx byte count", tx_bytes.size(), 26 + 16);
        if (tx_bytes.size() == 42) begin
            for (k = 0; k < 7; k++) begin
                check($sformatf("preamble %0d", k), tx_bytes[k], 8'h55);
            end
            check("sfd", tx_bytes[7], 8'hD5);
            for (k = 0; k < 6; k++) begin
                check($sformatf("dst mac %0d", k), tx_bytes[8 + k], mac_b[8 * (5 - k) +: 8]);
                check($sformatf("src mac %0d", k), tx_bytes[14 + k], mac_a[8 * (5 - k) +: 8]);
            end
            check("ethertype", {tx_bytes[20], tx_bytes[21]}, 16'h88B5);
            for (k = 0; k < 16; k++) begin
                check($sformatf("tx payload %0d", k), tx_bytes[22 + k], sent[k]);
            end
        end
        check("tready delay", tready_delay, 44);
    endtask

    task automatic test_loopback();
        logic [31:0] d;
        set_macs(mac_a, mac_a);
        set_control(1'b1, 20);
        send_frame(20);
        check_payload(20);
        axil_read(32'h14, d);
        check("status crc_err", d[0], 1'b0);
    endtask

    task automatic test_dest_filter();
        set_macs(mac_a, mac_b);
        set_control(1'b1, 20);
        send_frame(20);
        check("rx bytes, filter on", rx_data.size(), 0);
        set_control(1'b0, 20);
        send_frame(20);
        check_payload(20);
    endtask

    task automatic test_crc_error();
        logic [31:0] d;
        set_macs(mac_a, mac_a);
        set_control(1'b1, 20);
        @(posedge clk);
        corrupt_at <= 50; // low nibble of payload byte 3.
        send_frame(20);
        @(posedge clk);
        corrupt_at <= -1;
        axil_read(32'h14, d);
        check("status after bad fcs", d[0], 1'b1);
        axil_write(32'h14, 32'h1);
        axil_read(32'h14, d);
        check("status after clear", d[0], 1'b0);
    endtask

    initial begin
        arst_n = 1'b0;
        req    = '0;
        s_axis = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        test_reset_values();
        report_test("reset_values");
        test_reg_access();
        report_test("reg_access");
        test_tx_format();
        report_test("tx_format");
        test_loopback();
        report_test("loopback");
        test_dest_filter();
        report_test("dest_filter");
        test_crc_error();
        report_test("crc_error");
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- axil_rgmii.f
rtl/rgmii_pkg.sv
rtl/eth_crc32.sv
rtl/axil_reg_file.sv
rtl/rgmii_tx.sv
rtl/rgmii_rx.sv
rtl/axil_rgmii.sv
verif/tb_axil_rgmii.sv

//--- Makefile
TOP := tb_axil_rgmii

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f axil_rgmii.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
